// File: sources.f
rtl/rename_pkg.sv
rtl/commit_upd_if.sv
rtl/commit_map.sv
rtl/rename_map.sv
rtl/free_list.sv
rtl/rename_unit.sv
tb/tb_clkgen.sv
tb/tb_rename_unit.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_rename_unit
FILELIST = sources.f
PASS_MSG = Simulation completed successfully

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_rename_unit.sv
/*
 * Rename unit testbench
 * Drives dispatch and retire groups, predicts every rename with a
 * reference model and checks the DUT against it
 */

`timescale 1ns/1ps

module tb_rename_unit;
  import rename_pkg::*;

  localparam int TMO = 100;  // Cycles allowed for any wait

  typedef struct {
    logic [1:0] rv;
    areg_t      rd  [DISP_SIZE];
    rnid_t      rn  [DISP_SIZE];
    rnid_t      old [DISP_SIZE];
  } grp_t;

  logic clk, reset_n;
  logic i_rn_valid, o_rn_ready, i_cmt_valid;
  logic [DISP_SIZE-1:0] i_rn_rd_valid, i_cmt_rnid_valid, i_cmt_dead, i_cmt_except_valid;
  areg_t i_rn_rd_idx [DISP_SIZE], i_rn_rs1_idx [DISP_SIZE], i_rn_rs2_idx [DISP_SIZE];
  areg_t i_cmt_rd_idx [DISP_SIZE];
  rnid_t i_cmt_rd_rnid [DISP_SIZE], i_cmt_old_rnid [DISP_SIZE];
  rnid_t o_rn_rd_rnid [DISP_SIZE], o_rn_old_rnid [DISP_SIZE];
  rnid_t o_rn_rs1_rnid [DISP_SIZE], o_rn_rs2_rnid [DISP_SIZE];
  except_t i_cmt_except_type;

  // Reference model state
  rnid_t smap [NUM_AREGS];  // Speculative map
  rnid_t cmap [NUM_AREGS];  // Committed map
  rnid_t fl   [NUM_PREGS];  // Free rnid ring
  int    hd, tl, ch;        // Head, tail, committed head (unwrapped)
  rnid_t e_rd [DISP_SIZE], e_old [DISP_SIZE], e_rs1 [DISP_SIZE], e_rs2 [DISP_SIZE];
  grp_t  q [$];             // Renamed groups waiting to retire
  int    errs, mark, seed;

  tb_clkgen u_clkgen (.o_clk(clk), .o_reset_n(reset_n));

  rename_unit DUT (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_rn_valid(i_rn_valid), .o_rn_ready(o_rn_ready),
    .i_rn_rd_valid(i_rn_rd_valid), .i_rn_rd_idx(i_rn_rd_idx),
    .i_rn_rs1_idx(i_rn_rs1_idx), .i_rn_rs2_idx(i_rn_rs2_idx),
    .o_rn_rd_rnid(o_rn_rd_rnid), .o_rn_old_rnid(o_rn_old_rnid),
    .o_rn_rs1_rnid(o_rn_rs1_rnid), .o_rn_rs2_rnid(o_rn_rs2_rnid),
    .i_cmt_valid(i_cmt_valid), .i_cmt_rnid_valid(i_cmt_rnid_valid),
    .i_cmt_rd_idx(i_cmt_rd_idx), .i_cmt_rd_rnid(i_cmt_rd_rnid),
    .i_cmt_old_rnid(i_cmt_old_rnid), .i_cmt_dead(i_cmt_dead),
    .i_cmt_except_valid(i_cmt_except_valid), .i_cmt_except_type(i_cmt_except_type)
  );

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic void rename_ref();
    // Slots renamed one after another in program order
    for (int d = 0; d < DISP_SIZE; d++) begin
      e_rs1[d] = smap[i_rn_rs1_idx[d]];  // Sources read before own rd is written
      e_rs2[d] = smap[i_rn_rs2_idx[d]];
      e_old[d] = smap[i_rn_rd_idx[d]];
      e_rd[d]  = '0;
      if (i_rn_rd_valid[d]) begin
        e_rd[d] = fl[hd % NUM_PREGS];  // FIFO order
        hd++;
        smap[i_rn_rd_idx[d]] = e_rd[d];
      end
    end
  endfunction

  function automatic void retire_ref();
    logic kill;
    for (int d = 0; d < DISP_SIZE; d++) begin
      kill = i_cmt_dead[d] | (i_cmt_except_valid[d] & (i_cmt_except_type == EXC_TRAP));
      if (i_cmt_rnid_valid[d]) begin
        fl[tl % NUM_PREGS] = kill ? i_cmt_rd_rnid[d] : i_cmt_old_rnid[d];
        tl++;
        ch++;
        if (!kill) cmap[i_cmt_rd_idx[d]] = i_cmt_rd_rnid[d];
      end
    end
    cmap[0] = '0;
    if (|i_cmt_except_valid) begin  // Rollback to committed state
      for (int r = 0; r < NUM_AREGS; r++) smap[r] = cmap[r];
      hd = ch;
    end
  endfunction

  task automatic check_value(input string name, input int idx, input rnid_t exp, input rnid_t got);
    assert (exp == got) else begin
      $display("ERR %s[%0d] exp 0x%02h got 0x%02h", name, idx, exp, got);
      errs++;
    end
  endtask

  // ----------------------------------------
  // Comparing process
  // ----------------------------------------
  always @(posedge clk) begin : compare_p
    grp_t g;
    logic exp_ready;
    if (reset_n) begin
      exp_ready = (tl - hd >= DISP_SIZE) && !(i_cmt_valid && |i_cmt_except_valid);
      if (i_rn_valid) assert (o_rn_ready == exp_ready) else begin
        $display("ERR o_rn_ready exp 0x%0h got 0x%0h", exp_ready, o_rn_ready);
        errs++;
      end
      if (i_rn_valid && o_rn_ready) begin
        rename_ref();
        for (int d = 0; d < DISP_SIZE; d++) begin
          check_value("o_rn_rs1_rnid", d, e_rs1[d], o_rn_rs1_rnid[d]);
          check_value("o_rn_rs2_rnid", d, e_rs2[d], o_rn_rs2_rnid[d]);
          if (i_rn_rd_valid[d]) begin
            check_value("o_rn_rd_rnid", d, e_rd[d], o_rn_rd_rnid[d]);
            check_value("o_rn_old_rnid", d, e_old[d], o_rn_old_rnid[d]);
          end
          g.rd[d]  = i_rn_rd_idx[d];
          g.rn[d]  = e_rd[d];
          g.old[d] = e_old[d];
        end
        g.rv = i_rn_rd_valid;
        q.push_back(g);
      end
      if (i_cmt_valid) retire_ref();
    end
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  task automatic do_rename(input logic [1:0] rv, input areg_t rd0, input areg_t rd1,
                           input areg_t a0, input areg_t a1, input areg_t b0, input areg_t b1);
    int   cnt;
    logic acc;
    cnt = 0;
    acc = 1'b0;
    i_rn_valid    = 1'b1;
    i_rn_rd_valid = rv;
    i_rn_rd_idx   = '{rd0, rd1};
    i_rn_rs1_idx  = '{a0, a1};
    i_rn_rs2_idx  = '{b0, b1};
    while (!acc && cnt < TMO) begin  // Hold group until accepted
      @(posedge clk);
      acc = o_rn_ready;
      cnt++;
    end
    if (!acc) begin
      $display("Timeout waiting for rename group to be accepted");
      $display("Simulation failed");
      $finish;
    end else begin
      #1 i_rn_valid = 1'b0;
    end
  endtask

  task automatic load_retire(input logic [1:0] exm, input except_t ext, input logic [1:0] deadm);
    grp_t g;
    if (q.size() == 0) begin
      $display("Retire requested with no renamed group in flight");
      errs++;
    end else begin
      g = q.pop_front();
      i_cmt_valid        = (|g.rv) | (|exm);  // Empty group needs no notice
      i_cmt_rnid_valid   = g.rv;
      i_cmt_rd_idx       = g.rd;
      i_cmt_rd_rnid      = g.rn;
      i_cmt_old_rnid     = g.old;
      i_cmt_dead         = deadm;
      i_cmt_except_valid = exm;
      i_cmt_except_type  = ext;
    end
  endtask

  task automatic clear_retire();
    i_cmt_valid        = 1'b0;
    i_cmt_rnid_valid   = '0;
    i_cmt_dead         = '0;
    i_cmt_except_valid = '0;
    i_cmt_except_type  = EXC_NONE;
  endtask

  task automatic do_retire(input logic [1:0] exm, input except_t ext, input logic [1:0] deadm);
    load_retire(exm, ext, deadm);
    @(posedge clk);
    #1;
    if (i_cmt_valid && |exm) q.delete();  // Younger groups discarded
    clear_retire();
  endtask

  task automatic drain();
    while (q.size() > 0) do_retire(2'b00, EXC_NONE, 2'b00);
  endtask

  task automatic end_test(input string name);
    $display("test %-12s : %0d errors", name, errs - mark);
    mark = errs;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : stim_p
    int   cnt;
    logic pend, acc, fl_now;
    logic [1:0] exm, deadm;
    except_t ext;
    seed = 97084;
    errs = 0;
    mark = 0;
    i_rn_valid    = 1'b0;
    i_rn_rd_valid = '0;
    i_rn_rd_idx   = '{default: '0};
    i_rn_rs1_idx  = '{default: '0};
    i_rn_rs2_idx  = '{default: '0};
    i_cmt_rd_idx   = '{default: '0};
    i_cmt_rd_rnid  = '{default: '0};
    i_cmt_old_rnid = '{default: '0};
    clear_retire();
    for (int r = 0; r < NUM_AREGS; r++) begin  // Identity maps after reset
      smap[r] = rnid_t'(r);
      cmap[r] = rnid_t'(r);
    end
    for (int i = 0; i < NUM_PREGS; i++) fl[i] = rnid_t'(i + NUM_AREGS);
    hd = 0;
    tl = NUM_PREGS - NUM_AREGS;
    ch = 0;
    cnt = 0;
    while (!reset_n && cnt < TMO) begin
      @(posedge clk);
      cnt++;
      if (!reset_n) assert (o_rn_ready == 1'b0) else begin  // No rename during reset
        $display("ERR o_rn_ready exp 0x0 got 0x%0h", o_rn_ready);
        errs++;
      end
    end
    if (!reset_n) begin
      $display("Timeout waiting for reset release");
      $display("Simulation failed");
      $finish;
    end else begin
      assert (o_rn_ready == 1'b1) else begin  // Ready as soon as reset is gone
        $display("ERR o_rn_ready exp 0x1 got 0x%0h", o_rn_ready);
        errs++;
      end
      @(posedge clk);
      #1;
      do_rename(2'b11, 1, 2, 5, 0, 7, 31);  // Reset state and first rnids
      do_rename(2'b01, 9, 0, 0, 9, 12, 2);
      end_test("reset");
      do_rename(2'b11, 3, 3, 4, 3, 3, 1);  // Slot 1 sees slot 0's rd
      do_rename(2'b11, 6, 7, 6, 6, 2, 6);
      end_test("bypass");
      drain();
      while (tl - hd >= DISP_SIZE) do_rename(2'b11, 1, 2, 1, 2, 3, 4);
      assert (o_rn_ready == 1'b0) else begin
        $display("Rename ready stayed high with no free rnids");
        errs++;
      end
      drain();
      do_rename(2'b11, 5, 6, 1, 2, 5, 6);
      do_rename(2'b11, 7, 8, 1, 2, 3, 4);
      end_test("exhaust");
      drain();
      do_rename(2'b11, 1, 2, 3, 4, 5, 6);
      do_rename(2'b01, 3, 0, 1, 2, 0, 0);
      do_retire(2'b01, EXC_TRAP, 2'b10);  // Younger slot 1 marked dead
      do_rename(2'b11, 4, 5, 1, 2, 3, 1);
      end_test("trap");
      drain();
      do_rename(2'b11, 4, 5, 1, 4, 5, 6);
      do_rename(2'b11, 6, 4, 4, 5, 6, 0);
      do_retire(2'b01, EXC_SILENT_FLUSH, 2'b10);
      do_rename(2'b11, 7, 8, 4, 5, 6, 4);
      end_test("silent");
      pend = 1'b0;
      for (int cyc = 0; cyc < 2000; cyc++) begin
        if (!pend && $random(seed) % 2 != 0) begin
          i_rn_rd_valid = 2'($random(seed));
          for (int d = 0; d < DISP_SIZE; d++) begin
            i_rn_rd_idx[d]  = i_rn_rd_valid[d] ? areg_t'({$random(seed)} % 7 + 1) : '0;
            i_rn_rs1_idx[d] = areg_t'({$random(seed)} % 8);
            i_rn_rs2_idx[d] = areg_t'({$random(seed)} % 8);
          end
          i_rn_valid = 1'b1;
          pend = 1'b1;
        end
        if (q.size() > 0 && $random(seed) % 2 != 0) begin
          cnt   = {$random(seed)} % 16;
          exm   = (cnt < 2) ? 2'(1 << ({$random(seed)} % 2)) : 2'b00;
          ext   = (cnt == 0) ? EXC_TRAP : ((cnt == 1) ? EXC_SILENT_FLUSH : EXC_NONE);
          deadm = ({$random(seed)} % 4 == 0) ? 2'($random(seed)) : 2'b00;
          if (exm[0]) deadm[1] = 1'b1;
          load_retire(exm, ext, deadm);
        end
        @(posedge clk);
        acc    = i_rn_valid & o_rn_ready;
        fl_now = i_cmt_valid & (|i_cmt_except_valid);
        #1;
        if (acc) begin
          i_rn_valid = 1'b0;
          pend = 1'b0;
        end
        if (fl_now) q.delete();
        clear_retire();
      end
      end_test("random");
      $display("Checks done, %0d errors", errs);
      if (errs == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// File: tb/tb_clkgen.sv
/*
 * Testbench clock and reset
 * 8 ns clock, active-low reset held for two cycles
 */

`timescale 1ns/1ps

module tb_clkgen (
  output logic o_clk,
  output logic o_reset_n
);
  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;  // 8 ns period
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (2) @(posedge o_clk);
    #1 o_reset_n = 1'b1;  // Release off the edge
  end
endmodule

// File: rtl/rename_unit.sv
/*
 * Rename unit
 * Integer register rename for two-wide dispatch with commit tracking
 * and flush rollback
 */

`timescale 1ns/1ps

module rename_unit (
  input  logic                               i_clk,
  input  logic                               i_reset_n,
  // Rename side
  input  logic                               i_rn_valid,
  output logic                               o_rn_ready,
  input  logic [rename_pkg::DISP_SIZE-1:0]   i_rn_rd_valid,
  input  rename_pkg::areg_t                  i_rn_rd_idx    [rename_pkg::DISP_SIZE],
  input  rename_pkg::areg_t                  i_rn_rs1_idx   [rename_pkg::DISP_SIZE],
  input  rename_pkg::areg_t                  i_rn_rs2_idx   [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t                  o_rn_rd_rnid   [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t                  o_rn_old_rnid  [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t                  o_rn_rs1_rnid  [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t                  o_rn_rs2_rnid  [rename_pkg::DISP_SIZE],
  // Retire side
  input  logic                               i_cmt_valid,
  input  logic [rename_pkg::DISP_SIZE-1:0]   i_cmt_rnid_valid,
  input  rename_pkg::areg_t                  i_cmt_rd_idx   [rename_pkg::DISP_SIZE],
  input  rename_pkg::rnid_t                  i_cmt_rd_rnid  [rename_pkg::DISP_SIZE],
  input  rename_pkg::rnid_t                  i_cmt_old_rnid [rename_pkg::DISP_SIZE],
  input  logic [rename_pkg::DISP_SIZE-1:0]   i_cmt_dead,
  input  logic [rename_pkg::DISP_SIZE-1:0]   i_cmt_except_valid,
  input  rename_pkg::except_t                i_cmt_except_type
);
  import rename_pkg::*;

  logic [DISP_SIZE-1:0]  w_kill;
  logic                  w_flush;
  rnid_t                 w_map_next [NUM_AREGS];
  logic [FREE_CNT_W-1:0] w_free_cnt;
  logic                  w_rn_fire;

  // ----------------------------------------
  // Retire bundle
  // ----------------------------------------
  commit_upd_if u_cmt_if ();

  assign u_cmt_if.valid        = i_cmt_valid;
  assign u_cmt_if.rnid_valid   = i_cmt_rnid_valid;
  assign u_cmt_if.rd_idx       = i_cmt_rd_idx;
  assign u_cmt_if.rd_rnid      = i_cmt_rd_rnid;
  assign u_cmt_if.old_rnid     = i_cmt_old_rnid;
  assign u_cmt_if.dead         = i_cmt_dead;
  assign u_cmt_if.except_valid = i_cmt_except_valid;
  assign u_cmt_if.except_type  = i_cmt_except_type;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  // Room for a full group outside reset and rollback
  assign o_rn_ready = i_reset_n & (w_free_cnt >= FREE_CNT_W'(DISP_SIZE)) & ~w_flush;
  assign w_rn_fire  = i_rn_valid & o_rn_ready;

  commit_map u_commit_map (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .cmt        (u_cmt_if.map),
    .o_kill     (w_kill),
    .o_flush    (w_flush),
    .o_map_next (w_map_next)
  );

  rename_map u_rename_map (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rn_fire  (w_rn_fire),
    .i_rd_valid (i_rn_rd_valid),
    .i_rd_idx   (i_rn_rd_idx),
    .i_rs1_idx  (i_rn_rs1_idx),
    .i_rs2_idx  (i_rn_rs2_idx),
    .i_new_rnid (o_rn_rd_rnid),   // Straight from the free-list head
    .i_flush    (w_flush),
    .i_map_next (w_map_next),
    .o_rs1_rnid (o_rn_rs1_rnid),
    .o_rs2_rnid (o_rn_rs2_rnid),
    .o_old_rnid (o_rn_old_rnid)
  );

  free_list u_free_list (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_pop       (w_rn_fire),
    .i_pop_mask  (i_rn_rd_valid),
    .o_head_rnid (o_rn_rd_rnid),
    .o_free_cnt  (w_free_cnt),
    .cmt         (u_cmt_if.fl),
    .i_kill      (w_kill),
    .i_flush     (w_flush)
  );

endmodule

// File: rtl/free_list.sv
/*
 * Free list
 * Circular FIFO of free rnids; a committed head pointer lets the
 * allocation head roll back on flush
 */

`timescale 1ns/1ps

module free_list (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,
  input  logic                                  i_pop,
  input  logic [rename_pkg::DISP_SIZE-1:0]      i_pop_mask,
  output rename_pkg::rnid_t                     o_head_rnid [rename_pkg::DISP_SIZE],
  output logic [rename_pkg::FREE_CNT_W-1:0]     o_free_cnt,
  commit_upd_if.fl                              cmt,
  input  logic [rename_pkg::DISP_SIZE-1:0]      i_kill,
  input  logic                                  i_flush
);
  import rename_pkg::*;

  rnid_t                 r_fifo [NUM_PREGS];
  logic [FREE_CNT_W-1:0] r_head;       // Next rnid to hand out, with wrap bit
  logic [FREE_CNT_W-1:0] r_tail;       // Next free slot for a push
  logic [FREE_CNT_W-1:0] r_cmt_head;   // Head as seen by retired work
  logic [FREE_CNT_W-1:0] w_pop_cnt;
  logic [FREE_CNT_W-1:0] w_push_cnt;   // Also the committed head advance
  logic [FREE_CNT_W-1:0] w_push_ptr  [DISP_SIZE];
  rnid_t                 w_push_rnid [DISP_SIZE];
  logic [DISP_SIZE-1:0]  w_push_en;

  assign o_free_cnt = r_tail - r_head;

  // ----------------------------------------
  // Pop side
  // ----------------------------------------
  always_comb begin : pop_c
    logic [FREE_CNT_W-1:0] rd_ptr;
    w_pop_cnt = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      rd_ptr         = r_head + w_pop_cnt;  // Skip slots without rd
      o_head_rnid[d] = r_fifo[rd_ptr[RNID_W-1:0]];
      w_pop_cnt      = w_pop_cnt + FREE_CNT_W'(i_pop_mask[d]);
    end
  end

  // ----------------------------------------
  // Push side
  // ----------------------------------------
  always_comb begin : push_c
    w_push_cnt = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_push_en[d]   = cmt.valid & cmt.rnid_valid[d];
      // Live slot frees the old mapping, killed slot frees its own rnid
      w_push_rnid[d] = i_kill[d] ? cmt.rd_rnid[d] : cmt.old_rnid[d];
      w_push_ptr[d]  = r_tail + w_push_cnt;
      w_push_cnt     = w_push_cnt + FREE_CNT_W'(w_push_en[d]);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head     <= '0;
      r_tail     <= FREE_CNT_W'(NUM_PREGS - NUM_AREGS);  // 32 rnids free
      r_cmt_head <= '0;
    end else begin
      r_tail     <= r_tail + w_push_cnt;
      r_cmt_head <= r_cmt_head + w_push_cnt;
      if (i_flush) begin
        r_head <= r_cmt_head + w_push_cnt;  // Drop all in-flight allocations
      end else if (i_pop) begin
        r_head <= r_head + w_pop_cnt;
      end
    end
  end

  // Entries 0..31 start as rnids 32..63
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < NUM_PREGS; i++) begin
        r_fifo[i] <= rnid_t'(i + NUM_AREGS);
      end
    end else begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (w_push_en[d]) r_fifo[w_push_ptr[d][RNID_W-1:0]] <= w_push_rnid[d];
      end
    end
  end

  // Ready at the top must cover every pop
  a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_pop |-> (w_pop_cnt <= o_free_cnt));

  // 32 rnids always live in the maps, so at most 32 are ever free
  a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (w_push_cnt != '0) |=> (o_free_cnt <= FREE_CNT_W'(NUM_PREGS - NUM_AREGS)));

endmodule

// File: rtl/rename_map.sv
/*
 * Speculative rename map
 * Translates source and destination registers of a dispatch group,
 * with bypass inside the group and rollback to the committed map
 */

`timescale 1ns/1ps

module rename_map (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  input  logic                              i_rn_fire,
  input  logic [rename_pkg::DISP_SIZE-1:0]  i_rd_valid,
  input  rename_pkg::areg_t                 i_rd_idx   [rename_pkg::DISP_SIZE],
  input  rename_pkg::areg_t                 i_rs1_idx  [rename_pkg::DISP_SIZE],
  input  rename_pkg::areg_t                 i_rs2_idx  [rename_pkg::DISP_SIZE],
  input  rename_pkg::rnid_t                 i_new_rnid [rename_pkg::DISP_SIZE],
  input  logic                              i_flush,
  input  rename_pkg::rnid_t                 i_map_next [rename_pkg::NUM_AREGS],
  output rename_pkg::rnid_t                 o_rs1_rnid [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t                 o_rs2_rnid [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t                 o_old_rnid [rename_pkg::DISP_SIZE]
);
  import rename_pkg::*;

  rnid_t r_map      [NUM_AREGS];  // Speculative mapping
  rnid_t w_map_next [NUM_AREGS];

  // ----------------------------------------
  // Lookup
  // ----------------------------------------
  always_comb begin : lookup_c
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_rs1_rnid[d] = r_map[i_rs1_idx[d]];
      o_rs2_rnid[d] = r_map[i_rs2_idx[d]];
      o_old_rnid[d] = r_map[i_rd_idx[d]];
      // Older slots in the same group override the table, nearest last
      for (int p = 0; p < d; p++) begin
        if (i_rd_valid[p] && (i_rd_idx[p] == i_rs1_idx[d])) o_rs1_rnid[d] = i_new_rnid[p];
        if (i_rd_valid[p] && (i_rd_idx[p] == i_rs2_idx[d])) o_rs2_rnid[d] = i_new_rnid[p];
        if (i_rd_valid[p] && (i_rd_idx[p] == i_rd_idx[d]))  o_old_rnid[d] = i_new_rnid[p];
      end
      if (i_rs1_idx[d] == '0) o_rs1_rnid[d] = '0;  // x0 reads as 0
      if (i_rs2_idx[d] == '0) o_rs2_rnid[d] = '0;
      if (i_rd_idx[d] == '0)  o_old_rnid[d] = '0;
    end
  end

  // ----------------------------------------
  // Update
  // ----------------------------------------
  always_comb begin : update_c
    w_map_next = r_map;
    if (i_flush) begin
      w_map_next = i_map_next;  // Roll back to committed state
    end else if (i_rn_fire) begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_rd_valid[d]) w_map_next[i_rd_idx[d]] = i_new_rnid[d];  // Later slot wins
      end
    end
    w_map_next[0] = '0;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < NUM_AREGS; r++) begin
        r_map[r] <= rnid_t'(r);
      end
    end else begin
      r_map <= w_map_next;
    end
  end

  // Dispatch never asks for an x0 destination
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_chk
    a_no_x0_dest: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (i_rn_fire && i_rd_valid[d]) |-> (i_rd_idx[d] != '0));
  end

endmodule

// File: rtl/commit_map.sv
/*
 * Commit map
 * Architectural-to-physical map as seen by retired instructions; also
 * forms the per-slot kill mask and the flush request
 */

`timescale 1ns/1ps

module commit_map (
  input  logic                                 i_clk,
  input  logic                                 i_reset_n,
  commit_upd_if.map                            cmt,
  output logic [rename_pkg::DISP_SIZE-1:0]     o_kill,
  output logic                                 o_flush,
  output rename_pkg::rnid_t                    o_map_next [rename_pkg::NUM_AREGS]
);
  import rename_pkg::*;

  rnid_t r_commit_map [NUM_AREGS];  // Committed mapping
  logic  w_trap;                    // Group exception discards the slot

  // ----------------------------------------
  // Kill mask and flush
  // ----------------------------------------
  assign w_trap  = (cmt.except_type == EXC_TRAP);
  // Dead slots never commit, trapping slot is dropped too
  assign o_kill  = cmt.dead | (cmt.except_valid & {DISP_SIZE{w_trap}});
  assign o_flush = cmt.valid & (|cmt.except_valid);

  // ----------------------------------------
  // Next committed map
  // ----------------------------------------
  always_comb begin : next_map_c
    o_map_next = r_commit_map;
    if (cmt.valid) begin
      // Slot order, so a younger write to the same rd wins
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (cmt.rnid_valid[d] && !o_kill[d]) begin
          o_map_next[cmt.rd_idx[d]] = cmt.rd_rnid[d];
        end
      end
    end
    o_map_next[0] = '0;  // x0 pinned to rnid 0
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < NUM_AREGS; r++) begin
        r_commit_map[r] <= rnid_t'(r);  // Identity after reset
      end
    end else begin
      r_commit_map <= o_map_next;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_chk
    // Rename never allocates for x0, so retire must not report one
    a_no_x0_commit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (cmt.valid && cmt.rnid_valid[d]) |-> (cmt.rd_idx[d] != '0));
  end

  // Retire side only signals groups that carry something
  a_group_nonempty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    cmt.valid |-> (|(cmt.rnid_valid | cmt.except_valid)));

endmodule

// File: rtl/commit_upd_if.sv
/*
 * Commit update bundle
 * One retire group's rename information, driven by the top and read by
 * the commit map and the free list
 */

`timescale 1ns/1ps

interface commit_upd_if;
  import rename_pkg::*;

  logic                 valid;         // Group retires this cycle
  logic [DISP_SIZE-1:0] rnid_valid;    // Slot allocated an rnid at rename
  areg_t                rd_idx   [DISP_SIZE];
  rnid_t                rd_rnid  [DISP_SIZE];  // Rnid given at rename
  rnid_t                old_rnid [DISP_SIZE];  // Previous mapping of rd
  logic [DISP_SIZE-1:0] dead;          // Slot discarded, no architectural effect
  logic [DISP_SIZE-1:0] except_valid;  // Slot carries an exception
  except_t              except_type;   // One kind per group

  // Producer side
  modport src (output valid, rnid_valid, rd_idx, rd_rnid, old_rnid,
               dead, except_valid, except_type);

  // Committed map consumer
  modport map (input valid, rnid_valid, rd_idx, rd_rnid, dead,
               except_valid, except_type);

  // Free list consumer, pushes freed rnids
  modport fl (input valid, rnid_valid, rd_rnid, old_rnid);

endinterface

// File: rtl/rename_pkg.sv
/*
 * Register rename package
 * Sizes, index types and retire exception kinds shared by the integer
 * rename path
 */

package rename_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int DISP_SIZE  = 2;   // Slots per dispatch / retire group
  localparam int NUM_AREGS  = 32;  // x0..x31
  localparam int NUM_PREGS  = 64;  // Physical integer registers
  localparam int RNID_W     = 6;   // log2(NUM_PREGS)
  localparam int AREG_W     = 5;   // log2(NUM_AREGS)
  localparam int FREE_CNT_W = 7;   // Holds 0..NUM_PREGS, also pointer + wrap bit

  // ----------------------------------------
  // Types
  // ----------------------------------------
  typedef logic [RNID_W-1:0] rnid_t;  // Physical register ID
  typedef logic [AREG_W-1:0] areg_t;  // Architectural register index

  // Exception kind reported with a retire group
  typedef enum logic [1:0] {
    EXC_NONE         = 2'd0,  // Normal retire
    EXC_SILENT_FLUSH = 2'd1,  // Slot retires, younger work dropped
    EXC_TRAP         = 2'd2   // Slot dropped as well
  } except_t;

endpackage
